// File: Makefile
SIM        := verilator
TOP        := matmul_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Everything OK
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/matmul_pkg.sv
`default_nettype none

package matmul_pkg;

  //////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////
  localparam int MAT_SIZE     = 4;
  localparam int DATA_WIDTH   = 8;
  localparam int ACC_WIDTH    = 16;
  localparam int ADDR_WIDTH   = 8;
  localparam int STRIDE_WIDTH = 4;
  localparam int IDX_WIDTH    = $clog2(MAT_SIZE);

  // sequencer steps counted from the cycle after run
  localparam int STEP_WIDTH  = 4;
  // last operand has left cell (MAT_SIZE-1, MAT_SIZE-1) by this step
  localparam int DRAIN_START = 3 * MAT_SIZE - 1;
  localparam int LAST_STEP   = DRAIN_START + MAT_SIZE - 1;

  //////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////
  typedef logic [DATA_WIDTH-1:0]             elem_t;
  typedef logic [ACC_WIDTH-1:0]              acc_t;
  typedef elem_t [MAT_SIZE-1:0]              row_t;
  typedef acc_t [MAT_SIZE-1:0][MAT_SIZE-1:0] acc_grid_t;

  // one memory port request with a whole-row write
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  we;
    row_t                  wdata;
  } ram_req_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0]   base_a;
    logic [ADDR_WIDTH-1:0]   base_b;
    logic [ADDR_WIDTH-1:0]   base_c;
    logic [STRIDE_WIDTH-1:0] stride_a;
    logic [STRIDE_WIDTH-1:0] stride_b;
    logic [STRIDE_WIDTH-1:0] stride_c;
    logic [MAT_SIZE-1:0]     mask_a_rows;
    logic [MAT_SIZE-1:0]     mask_k;
    logic [MAT_SIZE-1:0]     mask_b_cols;
  } mat_cfg_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LAUNCH,
    ST_BUSY,
    ST_FINISHED
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/matmul_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module matmul_sequencer import matmul_pkg::*; (
  input  logic     clk,
  input  logic     resetn,
  input  logic     run,
  input  mat_cfg_t cfg,
  output ram_req_t a_req,
  output ram_req_t b_req,
  output ram_req_t c_req,
  input  row_t     a_rdata,
  input  row_t     b_rdata,
  output logic     finish
);

  logic                  busy;
  logic [STEP_WIDTH-1:0] step;
  logic                  reading;
  logic                  draining;
  logic                  rd_valid;
  logic [IDX_WIDTH-1:0]  rd_k;
  logic [IDX_WIDTH-1:0]  drain_row;
  row_t                  a_masked;
  row_t                  b_masked;
  row_t                  a_edge;
  row_t                  b_edge;
  row_t                  c_row;
  acc_grid_t             acc;

  // row address is base plus index times stride
  function automatic logic [ADDR_WIDTH-1:0] row_addr(
    input logic [ADDR_WIDTH-1:0]   base,
    input logic [STRIDE_WIDTH-1:0] stride,
    input logic [IDX_WIDTH-1:0]    idx
  );
    return base + ADDR_WIDTH'(idx) * ADDR_WIDTH'(stride);
  endfunction

  //////////////////////////////////////////////////////////////
  // step counter
  //////////////////////////////////////////////////////////////
  // read 0..MAT_SIZE-1, feed and settle, then drain to LAST_STEP
  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy <= 1'b0;
      step <= '0;
    end else if (run) begin
      busy <= 1'b1;
      step <= '0;
    end else if (busy) begin
      if (step == STEP_WIDTH'(LAST_STEP)) begin
        busy <= 1'b0;
      end
      step <= step + 1'b1;
    end
  end

  assign reading   = busy && (step < STEP_WIDTH'(MAT_SIZE));
  assign draining  = busy && (step >= STEP_WIDTH'(DRAIN_START));
  assign finish    = busy && (step == STEP_WIDTH'(LAST_STEP));
  assign drain_row = IDX_WIDTH'(step - STEP_WIDTH'(DRAIN_START));

  //////////////////////////////////////////////////////////////
  // operand reads and masking
  //////////////////////////////////////////////////////////////
  assign a_req = '{addr: row_addr(cfg.base_a, cfg.stride_a, step[IDX_WIDTH-1:0]),
                   we: 1'b0, wdata: '0};
  assign b_req = '{addr: row_addr(cfg.base_b, cfg.stride_b, step[IDX_WIDTH-1:0]),
                   we: 1'b0, wdata: '0};

  // memory answers a cycle later so track which k is on the read bus
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rd_valid <= 1'b0;
      rd_k     <= '0;
    end else begin
      rd_valid <= reading;
      rd_k     <= step[IDX_WIDTH-1:0];
    end
  end

  // zero lanes outside the valid window so the grid only adds zeros
  always_comb begin
    for (int n = 0; n < MAT_SIZE; n++) begin
      a_masked[n] = (rd_valid && cfg.mask_k[rd_k] && cfg.mask_a_rows[n]) ? a_rdata[n] : '0;
      b_masked[n] = (rd_valid && cfg.mask_k[rd_k] && cfg.mask_b_cols[n]) ? b_rdata[n] : '0;
    end
  end

  //////////////////////////////////////////////////////////////
  // skew with lane n delayed n cycles
  //////////////////////////////////////////////////////////////
  for (genvar n = 0; n < MAT_SIZE; n++) begin : g_skew
    if (n == 0) begin : g_direct
      assign a_edge[n] = a_masked[n];
      assign b_edge[n] = b_masked[n];
    end else begin : g_delay
      elem_t a_pipe [n];
      elem_t b_pipe [n];

      always_ff @(posedge clk) begin
        if (!resetn) begin
          for (int d = 0; d < n; d++) begin
            a_pipe[d] <= '0;
            b_pipe[d] <= '0;
          end
        end else begin
          a_pipe[0] <= a_masked[n];
          b_pipe[0] <= b_masked[n];
          for (int d = 1; d < n; d++) begin
            a_pipe[d] <= a_pipe[d-1];
            b_pipe[d] <= b_pipe[d-1];
          end
        end
      end

      assign a_edge[n] = a_pipe[n-1];
      assign b_edge[n] = b_pipe[n-1];
    end
  end

  // run clears every accumulator in the grid
  systolic_array u_array (
    .clk    (clk),
    .resetn (resetn),
    .clear  (run),
    .a_edge (a_edge),
    .b_edge (b_edge),
    .acc    (acc)
  );

  //////////////////////////////////////////////////////////////
  // drain of one C row per cycle
  //////////////////////////////////////////////////////////////
  // keep the low byte since masked rows and columns are already zero
  always_comb begin
    for (int j = 0; j < MAT_SIZE; j++) begin
      c_row[j] = acc[drain_row][j][DATA_WIDTH-1:0];
    end
  end

  assign c_req = '{addr: row_addr(cfg.base_c, cfg.stride_c, drain_row),
                   we: draining, wdata: c_row};

endmodule

`default_nettype wire

// File: rtl/matmul_top.sv
`timescale 1ns/10ps
`default_nettype none

module matmul_top import matmul_pkg::*; (
  input  logic     clk,
  input  logic     resetn,
  input  logic     start_reg,
  input  logic     clear_done_reg,
  input  mat_cfg_t cfg,
  output logic     done,
  input  ram_req_t ext_a,
  input  ram_req_t ext_b,
  input  ram_req_t ext_c,
  output row_t     ext_a_rdata,
  output row_t     ext_b_rdata,
  output row_t     ext_c_rdata
);

  ctrl_state_t state;
  logic        run;
  logic        finish;
  ram_req_t    a_req;
  ram_req_t    b_req;
  ram_req_t    c_req;
  ram_req_t    a_port0;
  ram_req_t    b_port0;
  row_t        a_rdata;
  row_t        b_rdata;

  //////////////////////////////////////////////////////////////
  // start/done control
  //////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_reg) begin
            state <= ST_LAUNCH;
          end
        end
        ST_LAUNCH: begin
          state <= ST_BUSY;
        end
        ST_BUSY: begin
          if (finish) begin
            state <= ST_FINISHED;
          end
        end
        ST_FINISHED: begin
          // start_reg is ignored here and only clear leaves
          if (clear_done_reg) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign run  = (state == ST_LAUNCH);
  assign done = (state == ST_FINISHED);

  //////////////////////////////////////////////////////////////
  // memories with port 0 internal and port 1 external
  //////////////////////////////////////////////////////////////
  // operand memories are never written from inside
  assign a_port0 = '{addr: a_req.addr, we: 1'b0, wdata: a_req.wdata};
  assign b_port0 = '{addr: b_req.addr, we: 1'b0, wdata: b_req.wdata};

  row_ram mem_a (
    .clk    (clk),
    .port0  (a_port0),
    .rdata0 (a_rdata),
    .port1  (ext_a),
    .rdata1 (ext_a_rdata)
  );

  row_ram mem_b (
    .clk    (clk),
    .port0  (b_port0),
    .rdata0 (b_rdata),
    .port1  (ext_b),
    .rdata1 (ext_b_rdata)
  );

  row_ram mem_c (
    .clk    (clk),
    .port0  (c_req),
    .rdata0 (),
    .port1  (ext_c),
    .rdata1 (ext_c_rdata)
  );

  matmul_sequencer u_seq (
    .clk     (clk),
    .resetn  (resetn),
    .run     (run),
    .cfg     (cfg),
    .a_req   (a_req),
    .b_req   (b_req),
    .c_req   (c_req),
    .a_rdata (a_rdata),
    .b_rdata (b_rdata),
    .finish  (finish)
  );

endmodule

`default_nettype wire

// File: rtl/row_ram.sv
`timescale 1ns/10ps
`default_nettype none

module row_ram import matmul_pkg::*; (
  input  logic     clk,
  input  ram_req_t port0,
  output row_t     rdata0,
  input  ram_req_t port1,
  output row_t     rdata1
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  row_t mem [DEPTH];

  //////////////////////////////////////////////////////////////
  // write side, both ports
  //////////////////////////////////////////////////////////////
  // a same-row collision between the ports has no defined winner
  always_ff @(posedge clk) begin
    if (port0.we) begin
      mem[port0.addr] <= port0.wdata;
    end
    if (port1.we) begin
      mem[port1.addr] <= port1.wdata;
    end
  end

  //////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////
  // registered every clock so data appears one cycle after the request
  always_ff @(posedge clk) begin
    rdata0 <= mem[port0.addr];
  end

  always_ff @(posedge clk) begin
    rdata1 <= mem[port1.addr];
  end

endmodule

`default_nettype wire

// File: rtl/systolic_array.sv
`timescale 1ns/10ps
`default_nettype none

module systolic_array import matmul_pkg::*; (
  input  logic      clk,
  input  logic      resetn,
  input  logic      clear,
  input  row_t      a_edge,
  input  row_t      b_edge,
  output acc_grid_t acc
);

  // horizontal A links with column MAT_SIZE as the far edge
  elem_t a_bus [MAT_SIZE][MAT_SIZE+1];
  // vertical B links with row MAT_SIZE as the bottom edge
  elem_t b_bus [MAT_SIZE+1][MAT_SIZE];

  //////////////////////////////////////////////////////////////
  // edge inputs already skewed by the sequencer
  //////////////////////////////////////////////////////////////
  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_a_edge
    assign a_bus[i][0] = a_edge[i];
  end

  for (genvar j = 0; j < MAT_SIZE; j++) begin : g_b_edge
    assign b_bus[0][j] = b_edge[j];
  end

  //////////////////////////////////////////////////////////////
  // cell grid
  //////////////////////////////////////////////////////////////
  // cell (i, j) sees A[i][k] and B[k][j] in the same cycle,
  // so its sum ends as C[i][j]
  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
      systolic_pe u_pe (
        .clk    (clk),
        .resetn (resetn),
        .clear  (clear),
        .a_in   (a_bus[i][j]),
        .b_in   (b_bus[i][j]),
        .a_out  (a_bus[i][j+1]),
        .b_out  (b_bus[i+1][j]),
        .acc    (acc[i][j])
      );
    end
  end

endmodule

`default_nettype wire

// File: rtl/systolic_pe.sv
`timescale 1ns/10ps
`default_nettype none

module systolic_pe import matmul_pkg::*; (
  input  logic  clk,
  input  logic  resetn,
  input  logic  clear,
  input  elem_t a_in,
  input  elem_t b_in,
  output elem_t a_out,
  output elem_t b_out,
  output acc_t  acc
);

  acc_t product;

  // unsigned 8x8 product fits the accumulator width exactly
  assign product = acc_t'(a_in) * acc_t'(b_in);

  always_ff @(posedge clk) begin
    if (!resetn || clear) begin
      a_out <= '0;
      b_out <= '0;
      acc   <= '0;
    end else begin
      // a moves right, b moves down
      a_out <= a_in;
      b_out <= b_in;
      acc   <= acc + product;
    end
  end

endmodule

`default_nettype wire

// File: sources.f
rtl/matmul_pkg.sv
rtl/row_ram.sv
rtl/systolic_pe.sv
rtl/systolic_array.sv
rtl/matmul_sequencer.sv
rtl/matmul_top.sv
test/matmul_chk.sv
test/matmul_tb.sv

// File: test/matmul_chk.sv
`timescale 1ns/10ps
`default_nettype none

module matmul_chk import matmul_pkg::*; (
  input wire logic        clk,
  input wire logic        resetn,
  input wire logic        done,
  input wire logic        clear_done_reg,
  input wire ctrl_state_t state,
  input wire ram_req_t    c_req
);

  // number of failed properties so far
  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // control output properties
  ////////////////////////////////////////////////////////////
  // done comes up low out of reset
  done_low_after_reset: assert property (@(posedge clk) !resetn |=> !done)
    else begin
      fail_count++;
      $error("done high in the cycle after reset");
    end

  // clear while done drops done on the next cycle
  done_falls_on_clear: assert property (@(posedge clk) disable iff (!resetn)
    (done && clear_done_reg) |=> !done)
    else begin
      fail_count++;
      $error("done still high after clear_done_reg");
    end

  // C writes belong to the busy window only
  no_c_write_outside_run: assert property (@(posedge clk) disable iff (!resetn)
    c_req.we |-> (!done && state != ST_IDLE))
    else begin
      fail_count++;
      $error("C memory write while idle or done");
    end

endmodule

`default_nettype wire

// File: test/matmul_tb.sv
`timescale 1ns/10ps
`default_nettype none

module matmul_tb import matmul_pkg::*; ();

  localparam logic [31:0] LCG_SEED = 32'h18d1fe50;
  localparam int RESET_CYCLES = 10;
  localparam int DONE_WAIT    = 100;
  localparam int RUNS_FULL    = 2;
  localparam int RUNS_MASK    = 4;
  localparam int RUNS_LAYOUT  = 4;
  // control test performs two runs of its own
  localparam int TIMEOUT_CYCLES = (RUNS_FULL + RUNS_MASK + RUNS_LAYOUT + 2) * 150;

  logic     clk;
  logic     resetn;
  logic     start_reg;
  logic     clear_done_reg;
  mat_cfg_t cfg;
  logic     done;
  ram_req_t ext_a;
  ram_req_t ext_b;
  ram_req_t ext_c;
  row_t     ext_a_rdata;
  row_t     ext_b_rdata;
  row_t     ext_c_rdata;

  logic [31:0] lcg_state;
  int          cycle_count = 0;
  // model copies of the operands indexed [row][col]
  elem_t       model_a [MAT_SIZE][MAT_SIZE];
  elem_t       model_b [MAT_SIZE][MAT_SIZE];

  matmul_top uut (
    .clk            (clk),
    .resetn         (resetn),
    .start_reg      (start_reg),
    .clear_done_reg (clear_done_reg),
    .cfg            (cfg),
    .done           (done),
    .ext_a          (ext_a),
    .ext_b          (ext_b),
    .ext_c          (ext_c),
    .ext_a_rdata    (ext_a_rdata),
    .ext_b_rdata    (ext_b_rdata),
    .ext_c_rdata    (ext_c_rdata)
  );

  bind matmul_top matmul_chk u_chk (
    .clk            (clk),
    .resetn         (resetn),
    .done           (done),
    .clear_done_reg (clear_done_reg),
    .state          (state),
    .c_req          (c_req)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: test did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1, "cycle limit reached");
    end
  end

  always @(negedge clk) begin
    if (uut.u_chk.fail_count != 0) begin
      $display("Assertion failure in the control checker");
      $display("Something failed");
      $fatal(1, "checker assertion failed");
    end
  end

  ////////////////////////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper halves only since the low LCG bits repeat quickly
  function automatic row_t rand_row();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] layout_addr(
    input logic [ADDR_WIDTH-1:0]   base,
    input logic [STRIDE_WIDTH-1:0] stride,
    input int                      idx
  );
    return ADDR_WIDTH'(int'(base) + idx * int'(stride));
  endfunction

  function automatic row_t expected_c_row(input int i);
    row_t        r;
    logic [31:0] sum;
    for (int j = 0; j < MAT_SIZE; j++) begin
      sum = '0;
      for (int k = 0; k < MAT_SIZE; k++) begin
        if (cfg.mask_k[k]) begin
          sum = sum + 32'(model_a[i][k]) * 32'(model_b[k][j]);
        end
      end
      r[j] = (cfg.mask_a_rows[i] && cfg.mask_b_cols[j]) ? sum[DATA_WIDTH-1:0] : '0;
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_row(input string name, input row_t exp, input row_t act);
    if (act !== exp) begin
      $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      $display("Something failed");
      $fatal(1, "row mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      $display("Something failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // external memory access where sel 0/1/2 picks A/B/C
  ////////////////////////////////////////////////////////////
  task automatic mem_write(input int sel, input logic [ADDR_WIDTH-1:0] addr, input row_t data);
    ram_req_t req;
    req = '{addr: addr, we: 1'b1, wdata: data};
    @(negedge clk);
    case (sel)
      0: ext_a = req;
      1: ext_b = req;
      default: ext_c = req;
    endcase
    @(negedge clk);
    ext_a.we = 1'b0;
    ext_b.we = 1'b0;
    ext_c.we = 1'b0;
  endtask

  // data is sampled on the falling edge after the registering clock
  task automatic mem_read(input int sel, input logic [ADDR_WIDTH-1:0] addr, output row_t data);
    ram_req_t req;
    req = '{addr: addr, we: 1'b0, wdata: '0};
    @(negedge clk);
    case (sel)
      0: ext_a = req;
      1: ext_b = req;
      default: ext_c = req;
    endcase
    @(negedge clk);
    case (sel)
      0: data = ext_a_rdata;
      1: data = ext_b_rdata;
      default: data = ext_c_rdata;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // run steps
  ////////////////////////////////////////////////////////////
  task automatic make_cfg(input bit rand_masks, input bit rand_layout, output mat_cfg_t c);
    logic [31:0] r;
    r = next_rand();
    c = '0;
    c.stride_a    = 1;
    c.stride_b    = 1;
    c.stride_c    = 1;
    c.mask_a_rows = '1;
    c.mask_k      = '1;
    c.mask_b_cols = '1;
    if (rand_masks) begin
      c.mask_a_rows = r[31:28];
      c.mask_k      = r[27:24];
      c.mask_b_cols = r[23:20];
    end
    if (rand_layout) begin
      c.base_a = r[31:24];
      c.base_b = r[23:16];
      r = next_rand();
      c.base_c   = r[31:24];
      c.stride_a = STRIDE_WIDTH'(1 + int'(r[23:20]) % 15);
      c.stride_b = STRIDE_WIDTH'(1 + int'(r[19:16]) % 15);
      c.stride_c = STRIDE_WIDTH'(1 + int'(r[15:12]) % 15);
    end
  endtask

  // A rows hold columns of A, B rows hold rows of B
  task automatic load_operands();
    row_t ra;
    row_t rb;
    for (int k = 0; k < MAT_SIZE; k++) begin
      ra = rand_row();
      rb = rand_row();
      for (int n = 0; n < MAT_SIZE; n++) begin
        model_a[n][k] = ra[n];
        model_b[k][n] = rb[n];
      end
      mem_write(0, layout_addr(cfg.base_a, cfg.stride_a, k), ra);
      mem_write(1, layout_addr(cfg.base_b, cfg.stride_b, k), rb);
    end
  endtask

  task automatic start_and_wait();
    int waited;
    waited = 0;
    @(negedge clk);
    start_reg = 1'b1;
    @(negedge clk);
    start_reg = 1'b0;
    while (!done && waited < DONE_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      $display("Timeout: done did not rise within %0d cycles of start", DONE_WAIT);
      $display("Something failed");
      $fatal(1, "done timeout");
    end
  endtask

  task automatic check_results(input bit use_filler, input row_t filler);
    row_t got;
    for (int i = 0; i < MAT_SIZE; i++) begin
      mem_read(2, layout_addr(cfg.base_c, cfg.stride_c, i), got);
      check_row($sformatf("ext_c_rdata (C row %0d)", i), expected_c_row(i), got);
    end
    if (use_filler) begin
      mem_read(2, cfg.base_c + 8'd1, got);
      check_row("ext_c_rdata (row between C rows)", filler, got);
    end
  endtask

  task automatic clear_done();
    @(negedge clk);
    check_bit("done", 1'b1, done);
    clear_done_reg = 1'b1;
    @(negedge clk);
    clear_done_reg = 1'b0;
    check_bit("done", 1'b0, done);
  endtask

  task automatic do_run(input bit rand_masks, input bit rand_layout);
    mat_cfg_t c;
    row_t     filler;
    bit       use_filler;
    make_cfg(rand_masks, rand_layout, c);
    @(negedge clk);
    cfg = c;
    load_operands();
    // a row between the first two C rows must survive the run
    use_filler = (cfg.stride_c >= 2);
    filler = rand_row();
    if (use_filler) begin
      mem_write(2, cfg.base_c + 8'd1, filler);
    end
    start_and_wait();
    check_results(use_filler, filler);
    clear_done();
  endtask

  task automatic memory_path_test();
    logic [ADDR_WIDTH-1:0] addr [MAT_SIZE];
    row_t                  data [MAT_SIZE];
    row_t                  got;
    logic [31:0]           r;
    for (int sel = 0; sel < 3; sel++) begin
      for (int n = 0; n < MAT_SIZE; n++) begin
        r = next_rand();
        // low bits from n keep the addresses distinct
        addr[n] = {r[29:24], n[1:0]};
        data[n] = rand_row();
        mem_write(sel, addr[n], data[n]);
      end
      for (int n = 0; n < MAT_SIZE; n++) begin
        mem_read(sel, addr[n], got);
        check_row($sformatf("ext rdata (memory %0d)", sel), data[n], got);
      end
    end
  endtask

  task automatic control_test();
    mat_cfg_t c;
    make_cfg(1'b1, 1'b0, c);
    @(negedge clk);
    cfg = c;
    load_operands();
    start_and_wait();
    repeat (5) begin
      @(negedge clk);
      check_bit("done", 1'b1, done);
    end
    // start while finished is ignored
    start_reg = 1'b1;
    repeat (2) @(negedge clk);
    start_reg = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_bit("done", 1'b1, done);
    end
    check_results(1'b0, '0);
    clear_done();
    repeat (2) begin
      @(negedge clk);
      check_bit("done", 1'b0, done);
    end
    do_run(1'b1, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    lcg_state      = LCG_SEED;
    resetn         = 1'b0;
    start_reg      = 1'b0;
    clear_done_reg = 1'b0;
    cfg            = '0;
    ext_a          = '0;
    ext_b          = '0;
    ext_c          = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    resetn = 1'b1;
    check_bit("done", 1'b0, done);
    memory_path_test();
    repeat (RUNS_FULL) do_run(1'b0, 1'b0);
    repeat (RUNS_MASK) do_run(1'b1, 1'b0);
    repeat (RUNS_LAYOUT) do_run(1'b0, 1'b1);
    control_test();
    if (uut.u_chk.fail_count != 0) begin
      $display("Assertion failure in the control checker");
      $display("Something failed");
      $fatal(1, "checker assertion failed");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire
